// ==== common/vseq_pkg.sv ====
// Shared definitions for the vector issue stage
// Sizing localparams and unit PE offsets
// Opcode and functional-unit enums with the opcode-to-unit function
// Dispatcher request and response, PE request and response, hazard vectors
package vseq_pkg;

  // Instructions in flight and register file size
  localparam int unsigned NrVInsn = 8;
  localparam int unsigned NrVRegs = 32;

  // Register v0 carries the mask
  localparam int unsigned VMask = 0;

  // Unit PEs sit above the lanes in every PE-indexed vector
  localparam int unsigned OffsetLoad  = 0;
  localparam int unsigned OffsetStore = 1;
  localparam int unsigned OffsetSlide = 2;
  localparam int unsigned OffsetMask  = 3;
  localparam int unsigned NrUnitPEs   = 4;

  typedef logic [$clog2(NrVInsn)-1:0] vid_t;
  typedef logic [$clog2(NrVRegs)-1:0] vreg_t;
  typedef logic [NrVInsn-1:0]         vinsn_vec_t;
  typedef logic [15:0]                vlen_t;
  typedef logic [31:0]                elen_t;

  // Grouped by unit so that range matching picks the unit
  typedef enum logic [3:0] {
    VADD, VSUB, VAND, VMUL, VMACC,
    VMAND, VMOR,
    VLE,
    VSE,
    VSLIDEUP, VMVXS
  } vop_e;

  typedef enum logic [2:0] {
    VFU_LANES, VFU_LOAD, VFU_STORE, VFU_SLIDE, VFU_MASK
  } vfu_e;

  function automatic vfu_e vop_unit(vop_e op);
    case (op) inside
      [VADD:VMACC]    : vop_unit = VFU_LANES;
      [VMAND:VMOR]    : vop_unit = VFU_MASK;
      VLE             : vop_unit = VFU_LOAD;
      VSE             : vop_unit = VFU_STORE;
      [VSLIDEUP:VMVXS]: vop_unit = VFU_SLIDE;
      default         : vop_unit = VFU_LANES;
    endcase
  endfunction

  // Decoded instruction from the dispatcher, vm high means unmasked
  typedef struct packed {
    vop_e  op;
    logic  vm;
    vreg_t vs1;
    logic  use_vs1;
    vreg_t vs2;
    logic  use_vs2;
    vreg_t vd;
    logic  use_vd;
    elen_t scalar_op;
    vlen_t vl;
  } vreq_t;

  typedef struct packed {
    elen_t resp;
    logic  error;
  } vresp_t;

  // Broadcast to every PE along with the dependency vectors
  typedef struct packed {
    vid_t       id;
    vop_e       op;
    vfu_e       vfu;
    logic       vm;
    vreg_t      vs1;
    logic       use_vs1;
    vreg_t      vs2;
    logic       use_vs2;
    vreg_t      vd;
    logic       use_vd;
    elen_t      scalar_op;
    vlen_t      vl;
    vinsn_vec_t hazard_vs1;
    vinsn_vec_t hazard_vs2;
    vinsn_vec_t hazard_vd;
    vinsn_vec_t hazard_vm;
    vinsn_vec_t vinsn_running;
  } pe_req_t;

  // One-cycle completion pulses, one bit per instruction ID
  typedef struct packed {
    vinsn_vec_t vinsn_done;
  } pe_resp_t;

  typedef struct packed {
    vinsn_vec_t hazard_vs1;
    vinsn_vec_t hazard_vs2;
    vinsn_vec_t hazard_vd;
    vinsn_vec_t hazard_vm;
  } hazard_t;

endpackage

// ==== sequencer/vinsn_tracker.sv ====
// Running-instruction tracker
// Per-PE table of running instruction IDs
// Lowest free ID search, full and idle flags
`timescale 1ns/1ps

module vinsn_tracker import vseq_pkg::*; #(
  parameter  int unsigned NrLanes = 2,
  localparam int unsigned NrPEs   = NrLanes + NrUnitPEs
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 issue_i,
  input  vid_t                 issue_id_i,
  input  logic     [NrPEs-1:0] issue_pes_i,
  input  pe_resp_t [NrPEs-1:0] pe_resp_i,
  output vinsn_vec_t           running_o,
  output vinsn_vec_t           running_next_o,
  output logic     [NrPEs-1:0] pe_busy_o,
  output vid_t                 next_id_o,
  output logic                 full_o,
  output logic                 idle_o
);

  // One running bit per PE and instruction ID
  logic [NrPEs-1:0][NrVInsn-1:0] pe_running_d, pe_running_q;

  always_comb begin
    pe_running_d   = pe_running_q;
    running_o      = '0;
    running_next_o = '0;
    for (int pe = 0; pe < NrPEs; pe++) begin
      // Done pulses retire first, a new issue sets on top
      pe_running_d[pe] &= ~pe_resp_i[pe].vinsn_done;
      if (issue_i && issue_pes_i[pe]) begin
        pe_running_d[pe][issue_id_i] = 1'b1;
      end
      running_o      |= pe_running_q[pe];
      running_next_o |= pe_running_d[pe];
      pe_busy_o[pe]   = |pe_running_q[pe];
    end
  end

  // Lowest clear bit of the running set
  always_comb begin
    next_id_o = '0;
    for (int i = NrVInsn - 1; i >= 0; i--) begin
      if (!running_o[i]) begin
        next_id_o = vid_t'(i);
      end
    end
  end

  assign full_o = &running_o;
  assign idle_o = ~|running_o;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pe_running_q <= '0;
    end else begin
      pe_running_q <= pe_running_d;
    end
  end

  // The sequencer only hands out IDs that are free in this table
  a_issue_free_id: assert property (@(posedge clk_i) disable iff (!rst_ni)
    issue_i |-> !running_o[issue_id_i]);

endmodule

// ==== sequencer/vreg_scoreboard.sv ====
// Vector register scoreboard
// Last writer and last reader per register
// Entries pruned once their instruction retires
// RAW, WAR and WAW hazard vectors for the issuing request
`timescale 1ns/1ps

module vreg_scoreboard import vseq_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       issue_i,
  input  vid_t       issue_id_i,
  input  vreq_t      issue_req_i,
  input  vinsn_vec_t running_i,
  output hazard_t    hazard_o
);

  typedef struct packed {
    vid_t vid;
    logic valid;
  } vreg_entry_t;

  vreg_entry_t [NrVRegs-1:0] wr_list_q, wr_list_d;
  vreg_entry_t [NrVRegs-1:0] rd_list_q, rd_list_d;

  // Pruned views of the lists, hazards are taken from these
  vreg_entry_t [NrVRegs-1:0] wr_live, rd_live;

  always_comb begin
    wr_live = wr_list_q;
    rd_live = rd_list_q;
    for (int v = 0; v < NrVRegs; v++) begin
      wr_live[v].valid &= running_i[wr_list_q[v].vid];
      rd_live[v].valid &= running_i[rd_list_q[v].vid];
    end
  end

  vreg_entry_t wr_vs1, wr_vs2, wr_vm, wr_vd, rd_vd;

  assign wr_vs1 = wr_live[issue_req_i.vs1];
  assign wr_vs2 = wr_live[issue_req_i.vs2];
  assign wr_vm  = wr_live[VMask];
  assign wr_vd  = wr_live[issue_req_i.vd];
  assign rd_vd  = rd_live[issue_req_i.vd];

  always_comb begin
    hazard_o = '0;

    // RAW on the sources and the mask
    if (issue_req_i.use_vs1 && wr_vs1.valid) begin
      hazard_o.hazard_vs1[wr_vs1.vid] = 1'b1;
    end
    if (issue_req_i.use_vs2 && wr_vs2.valid) begin
      hazard_o.hazard_vs2[wr_vs2.vid] = 1'b1;
    end
    if (!issue_req_i.vm && wr_vm.valid) begin
      hazard_o.hazard_vm[wr_vm.vid] = 1'b1;
    end

    if (issue_req_i.use_vd) begin
      // WAR, the pending reader of vd must fetch its operands first
      if (rd_vd.valid) begin
        hazard_o.hazard_vs1[rd_vd.vid] = 1'b1;
        hazard_o.hazard_vs2[rd_vd.vid] = 1'b1;
        hazard_o.hazard_vm[rd_vd.vid]  = 1'b1;
      end
      // WAW
      if (wr_vd.valid) begin
        hazard_o.hazard_vd[wr_vd.vid] = 1'b1;
      end
    end
  end

  // The issuing ID takes over vd as writer and its sources as reader
  always_comb begin
    wr_list_d = wr_live;
    rd_list_d = rd_live;
    if (issue_i) begin
      if (issue_req_i.use_vd) begin
        wr_list_d[issue_req_i.vd] = '{vid: issue_id_i, valid: 1'b1};
      end
      if (issue_req_i.use_vs1) begin
        rd_list_d[issue_req_i.vs1] = '{vid: issue_id_i, valid: 1'b1};
      end
      if (issue_req_i.use_vs2) begin
        rd_list_d[issue_req_i.vs2] = '{vid: issue_id_i, valid: 1'b1};
      end
      if (!issue_req_i.vm) begin
        rd_list_d[VMask] = '{vid: issue_id_i, valid: 1'b1};
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_list_q <= '0;
      rd_list_q <= '0;
    end else begin
      wr_list_q <= wr_list_d;
      rd_list_q <= rd_list_d;
    end
  end

endmodule

// ==== sequencer/vinsn_sequencer.sv ====
// Issue sequencer
// IDLE/WAIT FSM accepting dispatcher requests
// Target PE selection and store/mask structural check
// Registered PE request broadcast, dispatcher response path
`timescale 1ns/1ps

module vinsn_sequencer import vseq_pkg::*; #(
  parameter  int unsigned NrLanes = 2,
  localparam int unsigned NrPEs   = NrLanes + NrUnitPEs
) (
  input  logic             clk_i,
  input  logic             rst_ni,
  // Dispatcher
  input  vreq_t            req_i,
  input  logic             req_valid_i,
  output logic             req_ready_o,
  output vresp_t           resp_o,
  output logic             resp_valid_o,
  // PE broadcast
  output pe_req_t          pe_req_o,
  output logic             pe_req_valid_o,
  input  logic [NrPEs-1:0] pe_req_ready_i,
  // Tracker and scoreboard
  input  logic [NrPEs-1:0] pe_busy_i,
  input  vid_t             next_id_i,
  input  logic             full_i,
  input  vinsn_vec_t       running_next_i,
  input  hazard_t          hazard_i,
  output logic             issue_o,
  output vid_t             issue_id_o,
  output logic [NrPEs-1:0] issue_pes_o,
  output vreq_t            issue_req_o,
  // Scalar result and address generator
  input  elen_t            pe_scalar_resp_i,
  input  logic             pe_scalar_resp_valid_i,
  input  logic             addrgen_ack_i,
  input  logic             addrgen_error_i
);

  // WAIT holds the dispatcher until an ack or a scalar result
  typedef enum logic {
    IDLE,
    WAIT
  } seq_state_e;

  seq_state_e state_d, state_q;
  pe_req_t    pe_req_d;
  logic       pe_req_valid_d;

  vfu_e       vfu;
  logic       struct_hazard;
  logic       needs_wait;
  vinsn_vec_t own_bit;

  assign vfu = vop_unit(req_i.op);

  // Store unit and mask unit share one queue
  assign struct_hazard = (vfu == VFU_STORE && pe_busy_i[NrLanes + OffsetMask]) ||
                         (vfu == VFU_MASK  && pe_busy_i[NrLanes + OffsetStore]);

  // Memory ops wait for the address generator, VMVXS for its scalar
  assign needs_wait = (vfu == VFU_LOAD) || (vfu == VFU_STORE) || (req_i.op == VMVXS);

  assign own_bit = vinsn_vec_t'(1) << next_id_i;

  // Target PEs
  always_comb begin
    issue_pes_o = '0;
    unique case (vfu)
      VFU_LOAD : issue_pes_o[NrLanes + OffsetLoad]  = 1'b1;
      VFU_STORE: issue_pes_o[NrLanes + OffsetStore] = 1'b1;
      VFU_SLIDE: issue_pes_o[NrLanes + OffsetSlide] = 1'b1;
      VFU_MASK : issue_pes_o[NrLanes + OffsetMask]  = 1'b1;
      default  : issue_pes_o[NrLanes-1:0]           = '1;
    endcase
    // Masked instructions also need the mask unit
    if (!req_i.vm) begin
      issue_pes_o[NrLanes + OffsetMask] = 1'b1;
    end
  end

  assign issue_id_o  = next_id_i;
  assign issue_req_o = req_i;

  always_comb begin
    state_d        = state_q;
    req_ready_o    = 1'b0;
    resp_o         = '0;
    resp_valid_o   = 1'b0;
    issue_o        = 1'b0;
    pe_req_valid_d = 1'b0;

    // Hold the last request, dropping retired IDs from its vectors
    pe_req_d                = pe_req_o;
    pe_req_d.hazard_vs1    &= running_next_i;
    pe_req_d.hazard_vs2    &= running_next_i;
    pe_req_d.hazard_vd     &= running_next_i;
    pe_req_d.hazard_vm     &= running_next_i;
    pe_req_d.vinsn_running  = running_next_i;

    unique case (state_q)
      IDLE: begin
        if (req_valid_i && &pe_req_ready_i && !full_i && !struct_hazard) begin
          issue_o        = 1'b1;
          pe_req_valid_d = 1'b1;
          pe_req_d = '{
            id           : next_id_i,
            op           : req_i.op,
            vfu          : vfu,
            vm           : req_i.vm,
            vs1          : req_i.vs1,
            use_vs1      : req_i.use_vs1,
            vs2          : req_i.vs2,
            use_vs2      : req_i.use_vs2,
            vd           : req_i.vd,
            use_vd       : req_i.use_vd,
            scalar_op    : req_i.scalar_op,
            vl           : req_i.vl,
            hazard_vs1   : hazard_i.hazard_vs1 & running_next_i,
            hazard_vs2   : hazard_i.hazard_vs2 & running_next_i,
            hazard_vd    : hazard_i.hazard_vd & running_next_i,
            hazard_vm    : hazard_i.hazard_vm & running_next_i,
            vinsn_running: running_next_i & ~own_bit
          };
          if (needs_wait) begin
            state_d = WAIT;
          end else begin
            req_ready_o = 1'b1;
          end
        end
      end
      WAIT: begin
        if (pe_req_o.vfu == VFU_LOAD || pe_req_o.vfu == VFU_STORE) begin
          // Address translation outcome
          if (addrgen_ack_i) begin
            state_d      = IDLE;
            req_ready_o  = 1'b1;
            resp_valid_o = 1'b1;
            resp_o.error = addrgen_error_i;
          end
        end else if (pe_scalar_resp_valid_i) begin
          state_d      = IDLE;
          req_ready_o  = 1'b1;
          resp_valid_o = 1'b1;
          resp_o.resp  = pe_scalar_resp_i;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q        <= IDLE;
      pe_req_valid_o <= 1'b0;
    end else begin
      state_q        <= state_d;
      pe_req_valid_o <= pe_req_valid_d;
    end
  end

  always_ff @(posedge clk_i) begin
    pe_req_o <= pe_req_d;
  end

  // PEs see each instruction exactly once
  a_valid_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pe_req_valid_o |=> !pe_req_valid_o);

endmodule

// ==== design/vector_issue_top.sv ====
// Vector issue stage top level
// Running-instruction tracker, register scoreboard and issue sequencer
`timescale 1ns/1ps

module vector_issue_top import vseq_pkg::*; #(
  parameter  int unsigned NrLanes = 2,
  localparam int unsigned NrPEs   = NrLanes + NrUnitPEs
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  // Dispatcher
  input  vreq_t                req_i,
  input  logic                 req_valid_i,
  output logic                 req_ready_o,
  output vresp_t               resp_o,
  output logic                 resp_valid_o,
  output logic                 idle_o,
  // Processing elements
  output pe_req_t              pe_req_o,
  output logic                 pe_req_valid_o,
  input  logic     [NrPEs-1:0] pe_req_ready_i,
  input  pe_resp_t [NrPEs-1:0] pe_resp_i,
  // Slide unit scalar result
  input  elen_t                pe_scalar_resp_i,
  input  logic                 pe_scalar_resp_valid_i,
  // Address generator
  input  logic                 addrgen_ack_i,
  input  logic                 addrgen_error_i
);

  logic             issue;
  vid_t             issue_id;
  logic [NrPEs-1:0] issue_pes;
  vreq_t            issue_req;
  vinsn_vec_t       running;
  vinsn_vec_t       running_next;
  logic [NrPEs-1:0] pe_busy;
  vid_t             next_id;
  logic             full;
  hazard_t          hazard;

  vinsn_tracker #(
    .NrLanes(NrLanes)
  ) i_tracker (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .issue_i       (issue),
    .issue_id_i    (issue_id),
    .issue_pes_i   (issue_pes),
    .pe_resp_i     (pe_resp_i),
    .running_o     (running),
    .running_next_o(running_next),
    .pe_busy_o     (pe_busy),
    .next_id_o     (next_id),
    .full_o        (full),
    .idle_o        (idle_o)
  );

  // Pruned against the registered running set
  vreg_scoreboard i_scoreboard (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .issue_i    (issue),
    .issue_id_i (issue_id),
    .issue_req_i(issue_req),
    .running_i  (running),
    .hazard_o   (hazard)
  );

  vinsn_sequencer #(
    .NrLanes(NrLanes)
  ) i_sequencer (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .req_i                 (req_i),
    .req_valid_i           (req_valid_i),
    .req_ready_o           (req_ready_o),
    .resp_o                (resp_o),
    .resp_valid_o          (resp_valid_o),
    .pe_req_o              (pe_req_o),
    .pe_req_valid_o        (pe_req_valid_o),
    .pe_req_ready_i        (pe_req_ready_i),
    .pe_busy_i             (pe_busy),
    .next_id_i             (next_id),
    .full_i                (full),
    .running_next_i        (running_next),
    .hazard_i              (hazard),
    .issue_o               (issue),
    .issue_id_o            (issue_id),
    .issue_pes_o           (issue_pes),
    .issue_req_o           (issue_req),
    .pe_scalar_resp_i      (pe_scalar_resp_i),
    .pe_scalar_resp_valid_i(pe_scalar_resp_valid_i),
    .addrgen_ack_i         (addrgen_ack_i),
    .addrgen_error_i       (addrgen_error_i)
  );

endmodule

// ==== verif/tb_vector_issue.sv ====
// Directed testbench for the vector issue stage
// Models the PEs and the address generator around vector_issue_top
// Compare tasks for PE requests, dispatcher responses and single bits
// Tests cover reset, register hazards, ID exhaustion, store/mask conflict,
// PE back-pressure and the memory and scalar response paths
`timescale 1ns/1ps

module tb_vector_issue import vseq_pkg::*;;

  localparam int unsigned NrLanes = 2;
  localparam int unsigned NrPEs   = NrLanes + NrUnitPEs;
  // About four times the length of the whole test sequence
  localparam int unsigned MaxCycles = 400;
  // Longest wait for a single instruction to reach the PEs
  localparam int unsigned IssueWait = 20;
  localparam hazard_t     NoHazard  = '0;

  logic                 clk_i;
  logic                 rst_ni;
  vreq_t                req_i;
  logic                 req_valid_i;
  logic                 req_ready_o;
  vresp_t               resp_o;
  logic                 resp_valid_o;
  logic                 idle_o;
  pe_req_t              pe_req_o;
  logic                 pe_req_valid_o;
  logic     [NrPEs-1:0] pe_req_ready_i;
  pe_resp_t [NrPEs-1:0] pe_resp_i;
  elen_t                pe_scalar_resp_i;
  logic                 pe_scalar_resp_valid_i;
  logic                 addrgen_ack_i;
  logic                 addrgen_error_i;

  int     errors;
  int     checks;
  int     cycles;
  integer seed;

  vector_issue_top #(
    .NrLanes(NrLanes)
  ) i_dut (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .req_i                 (req_i),
    .req_valid_i           (req_valid_i),
    .req_ready_o           (req_ready_o),
    .resp_o                (resp_o),
    .resp_valid_o          (resp_valid_o),
    .idle_o                (idle_o),
    .pe_req_o              (pe_req_o),
    .pe_req_valid_o        (pe_req_valid_o),
    .pe_req_ready_i        (pe_req_ready_i),
    .pe_resp_i             (pe_resp_i),
    .pe_scalar_resp_i      (pe_scalar_resp_i),
    .pe_scalar_resp_valid_i(pe_scalar_resp_valid_i),
    .addrgen_ack_i         (addrgen_ack_i),
    .addrgen_error_i       (addrgen_error_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #50 clk_i = ~clk_i;
  end

  // Hard stop in case the DUT never answers
  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= MaxCycles) begin
      $display("Timeout: run did not finish within %0d cycles", MaxCycles);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  task automatic check_pe_req(input pe_req_t act, input pe_req_t exp, input string what);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Error at %0d ns: %s PE request got %h, expected %h", $time, what, act, exp);
    end
  endtask

  task automatic check_resp(input vresp_t act, input vresp_t exp, input string what);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Error at %0d ns: %s response got %h, expected %h", $time, what, act, exp);
    end
  endtask

  task automatic check_bit(input logic act, input logic exp, input string what);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Error at %0d ns: %s is %b, expected %b", $time, what, act, exp);
    end
  endtask

  function automatic vreq_t mk_req(vop_e op, logic vm, vreg_t vs1, logic u1,
                                   vreg_t vs2, logic u2, vreg_t vd, logic ud);
    mk_req = '{op: op, vm: vm, vs1: vs1, use_vs1: u1, vs2: vs2, use_vs2: u2,
               vd: vd, use_vd: ud, scalar_op: '0, vl: 16'd16};
  endfunction

  // Broadcast contents that the PEs should see for request r
  function automatic pe_req_t expect_req(vreq_t r, vid_t id, hazard_t hz, vinsn_vec_t others);
    pe_req_t e;
    e.id            = id;
    e.op            = r.op;
    e.vfu           = vop_unit(r.op);
    e.vm            = r.vm;
    e.vs1           = r.vs1;
    e.use_vs1       = r.use_vs1;
    e.vs2           = r.vs2;
    e.use_vs2       = r.use_vs2;
    e.vd            = r.vd;
    e.use_vd        = r.use_vd;
    e.scalar_op     = r.scalar_op;
    e.vl            = r.vl;
    e.hazard_vs1    = hz.hazard_vs1;
    e.hazard_vs2    = hz.hazard_vs2;
    e.hazard_vd     = hz.hazard_vd;
    e.hazard_vm     = hz.hazard_vm;
    e.vinsn_running = others;
    return e;
  endfunction

  // Loads, stores and VMVXS hold the dispatcher until their response
  function automatic logic holds_dispatcher(vop_e op);
    return op inside {VLE, VSE, VMVXS};
  endfunction

  task automatic start_req(input vreq_t r);
    @(negedge clk_i);
    req_i       = r;
    req_valid_i = 1'b1;
  endtask

  task automatic wait_issue(input pe_req_t exp, input string what);
    int waited;
    waited = 0;
    do begin
      @(posedge clk_i);
      @(negedge clk_i);
      waited++;
    end while (!pe_req_valid_o && waited < IssueWait);
    if (!pe_req_valid_o) begin
      errors++;
      $display("%s never reached the PEs within %0d cycles", what, IssueWait);
      req_valid_i = 1'b0;
    end else begin
      check_pe_req(pe_req_o, exp, what);
      if (!holds_dispatcher(exp.op)) begin
        req_valid_i = 1'b0;
      end
    end
  endtask

  task automatic issue_insn(input vreq_t r, input pe_req_t exp, input string what);
    start_req(r);
    wait_issue(exp, what);
  endtask

  task automatic expect_stall(input int n, input string what);
    repeat (n) begin
      #1;
      check_bit(req_ready_o, 1'b0, {what, " ready"});
      @(posedge clk_i);
      @(negedge clk_i);
      check_bit(pe_req_valid_o, 1'b0, {what, " PE valid"});
    end
  endtask

  // Done pulse from every PE for one ID
  task automatic retire(input vid_t id);
    @(negedge clk_i);
    for (int pe = 0; pe < NrPEs; pe++) begin
      pe_resp_i[pe].vinsn_done[id] = 1'b1;
    end
    @(negedge clk_i);
    pe_resp_i = '0;
  endtask

  task automatic ack_mem(input logic err);
    @(negedge clk_i);
    addrgen_ack_i   = 1'b1;
    addrgen_error_i = err;
    #1;
    check_bit(req_ready_o, 1'b1, "ack ready");
    check_bit(resp_valid_o, 1'b1, "ack resp valid");
    check_resp(resp_o, '{resp: '0, error: err}, "memory");
    @(negedge clk_i);
    addrgen_ack_i   = 1'b0;
    addrgen_error_i = 1'b0;
    req_valid_i     = 1'b0;
    #1;
    check_bit(resp_valid_o, 1'b0, "resp valid after ack");
  endtask

  task automatic reset_and_first_issue();
    vreq_t r;
    #1;
    check_bit(idle_o, 1'b1, "idle after reset");
    check_bit(pe_req_valid_o, 1'b0, "PE valid after reset");
    check_bit(resp_valid_o, 1'b0, "resp valid after reset");
    r = mk_req(VADD, 1'b1, 5'd1, 1'b1, 5'd2, 1'b1, 5'd4, 1'b1);
    issue_insn(r, expect_req(r, 3'd0, NoHazard, 8'h00), "first VADD");
    check_bit(idle_o, 1'b0, "idle while running");
    retire(3'd0);
    check_bit(idle_o, 1'b1, "idle after done");
  endtask

  task automatic register_hazards();
    vreq_t a, b, c;
    a = mk_req(VADD, 1'b1, 5'd1, 1'b1, 5'd2, 1'b1, 5'd3, 1'b1);
    b = mk_req(VMUL, 1'b1, 5'd3, 1'b1, 5'd6, 1'b1, 5'd3, 1'b1);
    c = mk_req(VSUB, 1'b1, 5'd7, 1'b1, 5'd8, 1'b1, 5'd3, 1'b1);
    issue_insn(a, expect_req(a, 3'd0, NoHazard, 8'h00), "VADD v3");
    // RAW on vs1 and WAW on vd against id 0
    issue_insn(b, expect_req(b, 3'd1, '{8'h01, 8'h00, 8'h01, 8'h00}, 8'h01), "VMUL v3");
    // WAR and WAW against id 1
    issue_insn(c, expect_req(c, 3'd2, '{8'h02, 8'h02, 8'h02, 8'h02}, 8'h03), "VSUB v3");
    retire(3'd1);
    check_pe_req(pe_req_o, expect_req(c, 3'd2, NoHazard, 8'h05), "held VSUB");
    retire(3'd0);
    retire(3'd2);
  endtask

  task automatic id_exhaustion();
    vreq_t r;
    for (int i = 0; i < NrVInsn; i++) begin
      r = mk_req(VADD, 1'b1, 5'd0, 1'b0, 5'd0, 1'b0, vreg_t'(8 + i), 1'b1);
      issue_insn(r, expect_req(r, vid_t'(i), NoHazard, vinsn_vec_t'((1 << i) - 1)), "fill");
    end
    r = mk_req(VADD, 1'b1, 5'd0, 1'b0, 5'd0, 1'b0, 5'd16, 1'b1);
    start_req(r);
    expect_stall(3, "ninth");
    retire(3'd5);
    wait_issue(expect_req(r, 3'd5, NoHazard, 8'hdf), "ninth");
    for (int i = 0; i < NrVInsn; i++) begin
      retire(vid_t'(i));
    end
  endtask

  task automatic store_mask_conflict();
    vreq_t st, mk, mv;
    st = mk_req(VSE, 1'b1, 5'd20, 1'b1, 5'd0, 1'b0, 5'd0, 1'b0);
    mk = mk_req(VMAND, 1'b1, 5'd22, 1'b1, 5'd23, 1'b1, 5'd21, 1'b1);
    mv = mk_req(VADD, 1'b0, 5'd25, 1'b1, 5'd26, 1'b1, 5'd24, 1'b1);
    issue_insn(st, expect_req(st, 3'd0, NoHazard, 8'h00), "VSE");
    ack_mem(1'b0);
    start_req(mk);
    expect_stall(3, "VMAND behind VSE");
    retire(3'd0);
    wait_issue(expect_req(mk, 3'd0, NoHazard, 8'h00), "VMAND");
    issue_insn(mv, expect_req(mv, 3'd1, NoHazard, 8'h01), "masked VADD");
    retire(3'd0);
    // Only the masked VADD keeps the mask unit busy now
    st.vs1 = 5'd27;
    start_req(st);
    expect_stall(3, "VSE behind masked VADD");
    retire(3'd1);
    wait_issue(expect_req(st, 3'd0, NoHazard, 8'h00), "second VSE");
    ack_mem(1'b0);
    retire(3'd0);
  endtask

  // A lane instruction still waits for a unit PE that is not ready
  task automatic pe_backpressure();
    vreq_t r;
    r = mk_req(VAND, 1'b1, 5'd9, 1'b1, 5'd10, 1'b1, 5'd11, 1'b1);
    start_req(r);
    pe_req_ready_i[NrLanes + OffsetSlide] = 1'b0;
    expect_stall(2, "VAND behind slide unit");
    pe_req_ready_i = '1;
    wait_issue(expect_req(r, 3'd0, NoHazard, 8'h00), "VAND after ready");
    retire(3'd0);
  endtask

  task automatic memory_response();
    vreq_t r;
    r = mk_req(VLE, 1'b1, 5'd0, 1'b0, 5'd0, 1'b0, 5'd28, 1'b1);
    issue_insn(r, expect_req(r, 3'd0, NoHazard, 8'h00), "VLE");
    expect_stall(2, "VLE wait");
    check_bit(resp_valid_o, 1'b0, "VLE resp before ack");
    ack_mem(1'b1);
    retire(3'd0);
  endtask

  task automatic scalar_response();
    vreq_t r;
    elen_t value;
    r = mk_req(VMVXS, 1'b1, 5'd0, 1'b0, 5'd29, 1'b1, 5'd0, 1'b0);
    issue_insn(r, expect_req(r, 3'd0, NoHazard, 8'h00), "VMVXS");
    @(negedge clk_i);
    value                  = $random(seed);
    pe_scalar_resp_i       = value;
    pe_scalar_resp_valid_i = 1'b1;
    #1;
    check_bit(req_ready_o, 1'b1, "scalar ready");
    check_bit(resp_valid_o, 1'b1, "scalar resp valid");
    check_resp(resp_o, '{resp: value, error: 1'b0}, "scalar");
    @(negedge clk_i);
    pe_scalar_resp_valid_i = 1'b0;
    req_valid_i            = 1'b0;
    retire(3'd0);
    check_bit(idle_o, 1'b1, "idle at end");
  endtask

  initial begin
    errors                 = 0;
    checks                 = 0;
    cycles                 = 0;
    seed                   = 32'h24e7_5fb8;
    rst_ni                 = 1'b0;
    req_i                  = '0;
    req_valid_i            = 1'b0;
    pe_req_ready_i         = '1;
    pe_resp_i              = '0;
    pe_scalar_resp_i       = '0;
    pe_scalar_resp_valid_i = 1'b0;
    addrgen_ack_i          = 1'b0;
    addrgen_error_i        = 1'b0;
    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    reset_and_first_issue();
    register_hazards();
    id_exhaustion();
    store_mask_conflict();
    pe_backpressure();
    memory_response();
    scalar_response();
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

// ==== filelist.f ====
common/vseq_pkg.sv
sequencer/vinsn_tracker.sv
sequencer/vreg_scoreboard.sv
sequencer/vinsn_sequencer.sv
design/vector_issue_top.sv
verif/tb_vector_issue.sv

// ==== Bender.yml ====
package:
  name: vector_issue

sources:
  # Shared package
  - common/vseq_pkg.sv
  # Issue stage blocks
  - sequencer/vinsn_tracker.sv
  - sequencer/vreg_scoreboard.sv
  - sequencer/vinsn_sequencer.sv
  # Top level
  - design/vector_issue_top.sv
  # Testbench
  - target: test
    files:
      - verif/tb_vector_issue.sv
